//--- Makefile
# Verilator build and run for the squeeze stage testbench.

VERILATOR ?= verilator
TOP ?= tb_squeeze
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Test completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The simulator binary is rebuilt only when a source, a header or the file list changes.
$(OBJ_DIR)/V%: $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

# The run fails unless the pass message shows up as a line of its own.
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- coeff_rom.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module coeff_rom (
	input logic clk,
	input logic [`SQ_TAP_AW-1:0] tap_addr,
	output squeeze_pkg::weight_vec_t weights,
	output squeeze_pkg::bias_vec_t biases
);

	// Weight table contents, a small signed ramp that differs per lane.
	function automatic logic [`SQ_WIDTH-1:0] rom_word(
		input logic [`SQ_TAP_AW-1:0] addr,
		input int lane
	);
		int v;
		v = ((int'(addr) * 7 + lane * 13) % 64) - 32; // range is -32 to 31.
		return `SQ_WIDTH'(v);
	endfunction

	// The read is registered, so a weight appears one cycle after its address.
	always_ff @(posedge clk) begin
		for (int i = 0; i < `SQ_LANES; i++) begin
			weights.w[i] <= rom_word(tap_addr, i);
		end
	end

	// Biases sit at bit 24, well above the kept fraction.
	always_comb begin
		for (int i = 0; i < `SQ_LANES; i++) begin
			biases.b[i] = `SQ_BIAS_W'(i) << 24;
		end
	end

endmodule

//--- mac_lane.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module mac_lane (
	input logic clk,
	input logic rst,
	input logic clr,
	input logic signed [`SQ_WIDTH-1:0] pix,
	input logic signed [`SQ_WIDTH-1:0] ker,
	output logic signed [`SQ_ACC_W-1:0] acc
);

	logic signed [2*`SQ_WIDTH-1:0] prod;

	assign prod = pix * ker; // full signed product.

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (clr) begin
			acc <= prod; // the first tap of a new group is loaded, not added.
		end else begin
			acc <= acc + prod;
		end
	end

endmodule

//--- ofm_ram.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module ofm_ram (
	input logic clk,
	input logic rst,
	input logic sample,
	input logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] wr_addr,
	input squeeze_pkg::ofm_vec_t ofm,
	input logic rd_en,
	input logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] rd_addr,
	output squeeze_pkg::ofm_vec_t rd_data,
	output logic ram_feedback
);

	import squeeze_pkg::*;

	localparam int DEPTH = `SQ_WOUT * `SQ_WOUT;
	localparam int AW = $clog2(DEPTH);

	ofm_vec_t mem [DEPTH];
	logic last_pend;
	logic last_wr;
	logic last_rd;

	assign last_wr = sample && (wr_addr == AW'(DEPTH - 1));
	assign last_rd = rd_en && (rd_addr == AW'(DEPTH - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			rd_data <= '0;
		end else begin
			if (sample) begin
				mem[wr_addr] <= ofm;
			end
			if (rd_en) begin
				rd_data <= mem[rd_addr]; // data is valid one cycle after rd_en.
			end
		end
	end

	// The last entry must be written before its read counts as the end of readout.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			last_pend <= 1'b0;
			ram_feedback <= 1'b0;
		end else begin
			ram_feedback <= last_rd && last_pend;
			if (last_wr) begin
				last_pend <= 1'b1;
			end else if (last_rd) begin
				last_pend <= 1'b0; // later rereads give no second pulse.
			end
		end
	end

endmodule

//--- squeeze_consts.svh
`ifndef SQUEEZE_CONSTS_SVH
`define SQUEEZE_CONSTS_SVH

// Sizes of the squeeze stage, shared by the design and the testbench.

`define SQ_LANES 4 // parallel multiply-accumulate lanes.

`define SQ_WIDTH 16 // pixel, weight and output word width.

`define SQ_TAPS 18 // a 3x3 kernel over two input channels.

`define SQ_WOUT 2 // side of the square output map.

`define SQ_ACC_W 33 // accumulator width, one guard bit above a full product.

`define SQ_BIAS_W 32 // per-lane bias width.

`define SQ_TAP_AW 5 // width of the coefficient ROM address.

`define SQ_FRAC 14 // lowest accumulator bit kept by requantization.

`endif

//--- squeeze_golden.txt
// words 0 to 71: input pixels, 16-bit signed hex, 18 taps per map position, tap 0 first.
// words 72 to 75: expected output vectors for positions 0 to 3, lane 3 in the high bits.
// position 0: 1000 on every tap, 3000 on tap 0.
0bb8 03e8 03e8 03e8 03e8 03e8
03e8 03e8 03e8 03e8 03e8 03e8
03e8 03e8 03e8 03e8 03e8 03e8
// position 1: -2000 on every tap, 8000 on tap 9.
f830 f830 f830 f830 f830 f830
f830 f830 f830 1f40 f830 f830
f830 f830 f830 f830 f830 f830
// position 2: -30000 on tap 4, 20000 on tap 13.
0000 0000 0000 0000 8ad0 0000
0000 0000 0000 0000 0000 0000
0000 4e20 0000 0000 0000 0000
// position 3: 12345 on tap 2, -7 on tap 7, 250 on tap 16.
0000 0000 3039 0000 0000 0000
0000 fff9 0000 0000 0000 0000
0000 0000 0000 0000 00fa 0000
// expected vectors, lane 0 is clamped to zero by the ReLU at positions 0 and 3.
0bff07ff03ff0000
0c0507fb03f00014
0c1007f103f90001
0c0f080503fc0000

//--- squeeze_layer.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module squeeze_layer (
	input logic clk,
	input logic rst,
	input logic en,
	input logic [`SQ_WIDTH-1:0] ifm,
	output logic [`SQ_TAP_AW-1:0] tap_addr,
	input squeeze_pkg::weight_vec_t weights,
	input squeeze_pkg::bias_vec_t biases,
	output logic sample,
	output logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] wr_addr,
	output squeeze_pkg::ofm_vec_t ofm,
	input logic ram_feedback,
	output logic finish
);

	import squeeze_pkg::*;

	localparam int POS = `SQ_WOUT * `SQ_WOUT;
	localparam int AW = $clog2(POS);

	logic [AW:0] grp_cnt;
	logic consume;
	logic last_tap;
	logic [2:0] mark;
	logic clr;
	logic [`SQ_WIDTH-1:0] pix_d1;
	logic [`SQ_WIDTH-1:0] pix_d2;
	weight_vec_t w_reg;
	logic signed [`SQ_ACC_W-1:0] acc [`SQ_LANES];
	logic signed [`SQ_ACC_W-1:0] sum [`SQ_LANES];
	ofm_vec_t q;
	logic layer_end;
	logic fb_seen;

	// Pixels are taken only until every group of the map has been consumed.
	assign consume = en && (grp_cnt != (AW+1)'(POS));
	assign last_tap = (tap_addr == `SQ_TAP_AW'(`SQ_TAPS - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_addr <= '0;
			grp_cnt <= '0;
		end else if (consume) begin
			if (last_tap) begin
				tap_addr <= '0;
				grp_cnt <= grp_cnt + 1'b1;
			end else begin
				tap_addr <= tap_addr + 1'b1;
			end
		end
	end

	// Stage 1 meets the ROM read, stage 2 meets the weight register.
	// An idle cycle feeds a zero pixel, which adds nothing to the sums.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_d1 <= '0;
			pix_d2 <= '0;
		end else begin
			pix_d1 <= consume ? ifm : '0;
			pix_d2 <= pix_d1;
		end
	end

	always_ff @(posedge clk) begin
		w_reg <= weights;
	end

	// The group-end mark follows the last pixel down the same pipeline.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mark <= '0;
		end else begin
			mark <= {mark[1:0], consume && last_tap};
		end
	end

	assign clr = mark[2]; // high while the next group's first product is presented.

	for (genvar i = 0; i < `SQ_LANES; i++) begin : g_lane
		mac_lane u_mac (
			.clk(clk),
			.rst(rst),
			.clr(clr),
			.pix($signed(pix_d2)),
			.ker($signed(w_reg.w[i])),
			.acc(acc[i])
		);
	end

	// Bias, ReLU and cut from Q-format down to a 16-bit word.
	always_comb begin
		for (int i = 0; i < `SQ_LANES; i++) begin
			sum[i] = acc[i] + $signed(biases.b[i]);
			if (sum[i][`SQ_ACC_W-1]) begin
				q.word[i] = '0;
			end else begin
				q.word[i] = {1'b0, sum[i][`SQ_FRAC +: `SQ_WIDTH-1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clr) begin
			ofm <= q; // the finished group is captured as the accumulators restart.
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample <= 1'b0;
			wr_addr <= '0;
			layer_end <= 1'b0;
			fb_seen <= 1'b0;
		end else begin
			sample <= clr;
			if (sample) begin
				wr_addr <= wr_addr + 1'b1; // one map position per sample.
			end
			if (sample && wr_addr == AW'(POS - 1)) begin
				layer_end <= 1'b1;
			end
			if (ram_feedback) begin
				fb_seen <= 1'b1; // the reader has fetched the whole map.
			end
		end
	end

	assign finish = layer_end && !fb_seen;

endmodule

//--- squeeze_pkg.sv
`include "squeeze_consts.svh"

package squeeze_pkg;

	// One output vector, a 16-bit word per lane, lane 0 in the low bits.
	typedef struct packed {
		logic [`SQ_LANES-1:0][`SQ_WIDTH-1:0] word;
	} ofm_vec_t;

	// Weights for one tap address, a signed word per lane.
	typedef struct packed {
		logic [`SQ_LANES-1:0][`SQ_WIDTH-1:0] w;
	} weight_vec_t;

	// Constant biases, already aligned to the accumulator fraction.
	typedef struct packed {
		logic [`SQ_LANES-1:0][`SQ_BIAS_W-1:0] b;
	} bias_vec_t;

endpackage

//--- squeeze_sva.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module squeeze_sva (
	input logic clk,
	input logic rst,
	input logic sample,
	input logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] wr_addr,
	input logic ram_feedback,
	input logic finish
);

	localparam int POS = `SQ_WOUT * `SQ_WOUT;
	localparam int AW = $clog2(POS);

	logic [2:0] samples_seen;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			samples_seen <= '0;
		end else if (sample && samples_seen != 3'd7) begin
			samples_seen <= samples_seen + 1'b1; // saturates well above the map size.
		end
	end

	a_sample_pulse: assert property (@(posedge clk) disable iff (!rst) sample |=> !sample)
		else $error("sample stayed high for two cycles");

	// Each write goes to the position of its own group, and no write follows the map.
	a_wr_addr_order: assert property (@(posedge clk) disable iff (!rst)
		sample |-> (samples_seen < 3'(POS) && wr_addr == samples_seen[AW-1:0]))
		else $error("write address %0d does not follow sample %0d", wr_addr, samples_seen);

	a_finish_late: assert property (@(posedge clk) disable iff (!rst)
		$rose(finish) |-> (samples_seen >= 3'(POS)))
		else $error("finish rose after only %0d samples", samples_seen);

	// ram_feedback is the pulse from the output RAM as the layer receives it.
	a_feedback_pulse: assert property (@(posedge clk) disable iff (!rst)
		ram_feedback |=> !ram_feedback)
		else $error("ram_feedback stayed high for two cycles");

endmodule

bind squeeze_layer squeeze_sva u_sva (
	.clk(clk),
	.rst(rst),
	.sample(sample),
	.wr_addr(wr_addr),
	.ram_feedback(ram_feedback),
	.finish(finish)
);

//--- squeeze_top.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module squeeze_top (
	input logic clk,
	input logic rst,
	input logic en,
	input logic [`SQ_WIDTH-1:0] ifm,
	input logic rd_en,
	input logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] rd_addr,
	output squeeze_pkg::ofm_vec_t rd_data,
	output logic finish
);

	import squeeze_pkg::*;

	localparam int AW = $clog2(`SQ_WOUT * `SQ_WOUT);

	logic [`SQ_TAP_AW-1:0] tap_addr;
	weight_vec_t weights;
	bias_vec_t biases;
	logic sample;
	logic [AW-1:0] wr_addr;
	ofm_vec_t ofm;
	logic ram_feedback;

	squeeze_layer u_layer (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ifm(ifm),
		.tap_addr(tap_addr),
		.weights(weights),
		.biases(biases),
		.sample(sample),
		.wr_addr(wr_addr),
		.ofm(ofm),
		.ram_feedback(ram_feedback),
		.finish(finish)
	);

	coeff_rom u_rom (
		.clk(clk),
		.tap_addr(tap_addr),
		.weights(weights),
		.biases(biases)
	);

	ofm_ram u_ram (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.wr_addr(wr_addr),
		.ofm(ofm),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.ram_feedback(ram_feedback)
	);

endmodule

//--- src.f
+incdir+.
squeeze_pkg.sv
coeff_rom.sv
mac_lane.sv
squeeze_layer.sv
ofm_ram.sv
squeeze_top.sv
squeeze_sva.sv
tb_squeeze.sv

//--- tb_squeeze.sv
`timescale 1ns/1ns

`include "squeeze_consts.svh"

module tb_squeeze;

	import squeeze_pkg::*;

	localparam int POS = `SQ_WOUT * `SQ_WOUT;
	localparam int AW = $clog2(POS);
	localparam int NPIX = POS * `SQ_TAPS;
	localparam int WAIT_LIMIT = 100; // cycles allowed for any single wait.

	logic clk;
	logic rst;
	logic en;
	logic [`SQ_WIDTH-1:0] ifm;
	logic rd_en;
	logic [AW-1:0] rd_addr;
	ofm_vec_t rd_data;
	logic finish;

	logic [63:0] golden [NPIX + POS]; // pixels first, then one expected vector per position.
	int errors;
	int errors_at_start;
	int tests_passed;
	int tests_failed;

	squeeze_top DUT (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ifm(ifm),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.finish(finish)
	);

	always #50 clk = ~clk;

	task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s (got %h, expected %h)", $time, msg, actual, expected);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d mismatch(es)", name, errors - errors_at_start);
			tests_failed++;
		end
		errors_at_start = errors;
	endtask

	// rd_data is registered, so it is taken on the falling edge after the read edge.
	task automatic read_entry(input logic [AW-1:0] addr, output ofm_vec_t data);
		rd_en = 1'b1;
		rd_addr = addr;
		@(negedge clk);
		rd_en = 1'b0;
		data = rd_data;
	endtask

	// finish must hold its given level on every cycle of the stream.
	task automatic stream_pixels(input int first, input int count, input logic finish_level);
		for (int k = 0; k < count; k++) begin
			en = 1'b1;
			ifm = golden[first + k][`SQ_WIDTH-1:0];
			@(negedge clk);
			compare_value(64'(finish), 64'(finish_level), "finish level changed while streaming");
		end
		en = 1'b0;
		ifm = '0;
	endtask

	task automatic wait_for_finish(input logic level, input string what);
		int n;
		n = 0;
		while (finish !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (finish !== level) begin
			$display("timeout: finish did not go %s within %0d cycles", what, WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic check_all_entries(input logic finish_level, input string when);
		ofm_vec_t data;
		for (int a = 0; a < POS; a++) begin
			read_entry(AW'(a), data);
			compare_value(data, golden[NPIX + a], $sformatf("entry %0d %s", a, when));
			compare_value(64'(finish), 64'(finish_level), $sformatf("finish after entry %0d", a));
		end
	endtask

	initial begin
		ofm_vec_t data;
		clk = 1'b0;
		rst = 1'b0;
		en = 1'b0;
		ifm = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		errors = 0;
		errors_at_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		$readmemh("squeeze_golden.txt", golden);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		compare_value(64'(finish), 64'd0, "finish high after reset");
		for (int a = 0; a < POS; a++) begin
			read_entry(AW'(a), data);
			compare_value(data, '0, $sformatf("entry %0d not cleared by reset", a));
		end
		end_test("reset state");

		stream_pixels(0, NPIX, 1'b0); // finish stays low until the whole map is in.
		wait_for_finish(1'b1, "high after the last group");
		read_entry('0, data);
		compare_value(data, golden[NPIX], "entry 0 differs from the golden vector");
		compare_value(64'(finish), 64'd1, "finish dropped after reading entry 0");
		end_test("output values");

		for (int a = 1; a < POS - 1; a++) begin
			read_entry(AW'(a), data);
			compare_value(data, golden[NPIX + a], $sformatf("entry %0d differs from golden", a));
			compare_value(64'(finish), 64'd1, $sformatf("finish dropped after entry %0d", a));
		end
		end_test("group boundaries");

		// the pixels of position 1 would turn entry 0 into a different vector if taken.
		stream_pixels(`SQ_TAPS, `SQ_TAPS, 1'b1);
		repeat (6) @(negedge clk);
		for (int a = 0; a < POS - 1; a++) begin
			read_entry(AW'(a), data);
			compare_value(data, golden[NPIX + a], $sformatf("entry %0d after extra pixels", a));
			compare_value(64'(finish), 64'd1, $sformatf("finish dropped after entry %0d", a));
		end
		end_test("finish rises");

		read_entry(AW'(POS - 1), data);
		compare_value(data, golden[NPIX + POS - 1], "last entry differs from the golden vector");
		wait_for_finish(1'b0, "low after the last entry was read");
		repeat (10) begin
			@(negedge clk);
			compare_value(64'(finish), 64'd0, "finish rose again after readout");
		end
		check_all_entries(1'b0, "on reread after readout");
		end_test("finish falls");

		$display("summary: %0d tests ok, %0d with errors, %0d mismatches", tests_passed,
			tests_failed, errors);
		if (tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
